//--- flist.f
+incdir+include
source/calc_pkg.sv
source/calc_rsv_if.sv
source/calc_fwd_if.sv
source/calc_issue.sv
source/calc_pipe_int.sv
source/calc_pipe_mul.sv
source/calc_comp_pipe.sv
source/calc_top.sv
tests/calc_tb.sv

//--- tests/calc_tb.sv
/*
 * Execution calculator testbench
 *
 * Drives directed and random instruction streams into the calculator,
 * predicts every writeback from a reference register file and checks
 * the writeback port cycle by cycle.
 */

`include "calc_consts.svh"

module calc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // About 400 dispatches with bubbles and drain fit well below this
  localparam int max_cycles = 1000;

  typedef struct
  {
    int                              due;
    logic [`CALC_REG_ADDR_WIDTH-1:0] rd;
    logic [`CALC_DPATH_WIDTH-1:0]    data;
  } wb_entry_t;

  logic clk_i, rst_i, dispatch_v_i, poison_i, wb_v_o;
  calc_pkg::alu_op_e dispatch_op_i;
  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rs1_addr_i, dispatch_rs2_addr_i;
  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rd_addr_i, wb_rd_addr_o;
  logic [`CALC_DPATH_WIDTH-1:0] dispatch_rs1_i, dispatch_rs2_i, wb_data_o;

  int cycle_cnt = 0;
  int err_cnt = 0;
  int seed = 32;
  logic [`CALC_DPATH_WIDTH-1:0] arch_rf [32];
  logic [`CALC_DPATH_WIDTH-1:0] stale_rf [32];
  logic [`CALC_REG_ADDR_WIDTH-1:0] mul_rd = '0;
  wb_entry_t exp_q [$];
  wb_entry_t stale_q [$];

  calc_top calc_top_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #10;
      cycle_cnt = cycle_cnt + 1;
      clk_i = 1'b1;
      #10;
      clk_i = 1'b0;
    end
  end

  function automatic logic [`CALC_DPATH_WIDTH-1:0] alu_ref
    (input calc_pkg::alu_op_e op, input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod;
    prod = a * b;
    case (op)
      calc_pkg::e_add: return a + b;
      calc_pkg::e_sub: return a - b;
      calc_pkg::e_and: return a & b;
      calc_pkg::e_or:  return a | b;
      calc_pkg::e_xor: return a ^ b;
      calc_pkg::e_sll: return a << b[4:0];
      calc_pkg::e_srl: return a >> b[4:0];
      default:         return prod[31:0];
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h (cycle %0d)", name, got, exp, cycle_cnt);
      err_cnt++;
    end
  endtask

  // Results whose writeback cycle has passed become visible to dispatch
  function automatic void retire_stale();
    while (stale_q.size() != 0 && stale_q[0].due <= cycle_cnt)
    begin
      stale_rf[stale_q[0].rd] = stale_q[0].data;
      void'(stale_q.pop_front());
    end
  endfunction

  task automatic idle_cycle();
    @(posedge clk_i);
    retire_stale();
    dispatch_v_i <= 1'b0;
    poison_i     <= 1'b0;
    mul_rd = '0;
  endtask

  task automatic issue_instr(input calc_pkg::alu_op_e op, input logic [4:0] a1,
                             input logic [4:0] a2, input logic [4:0] rd, input logic kill);
    wb_entry_t ent;
    // A multiply result cannot be read in the very next slot
    if (mul_rd != '0 && (a1 == mul_rd || a2 == mul_rd))
      idle_cycle();
    @(posedge clk_i);
    retire_stale();
    dispatch_v_i        <= 1'b1;
    dispatch_op_i       <= op;
    dispatch_rs1_addr_i <= a1;
    dispatch_rs2_addr_i <= a2;
    dispatch_rd_addr_i  <= rd;
    dispatch_rs1_i      <= stale_rf[a1];
    dispatch_rs2_i      <= stale_rf[a2];
    poison_i            <= kill;
    mul_rd = (op == calc_pkg::e_mul && !kill) ? rd : '0;
    if (!kill && rd != '0)
    begin
      ent.due  = cycle_cnt + 4;
      ent.rd   = rd;
      ent.data = alu_ref(op, arch_rf[a1], arch_rf[a2]);
      arch_rf[rd] = ent.data;
      exp_q.push_back(ent);
      ent.due = cycle_cnt + 5;
      stale_q.push_back(ent);
    end
  endtask

  always @(negedge clk_i)
  begin : compare
    wb_entry_t exp;
    if (!rst_i)
    begin
      if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt)
      begin
        exp = exp_q.pop_front();
        if (wb_v_o !== 1'b1)
        begin
          $display("Missing writeback for rd %0d in cycle %0d", exp.rd, cycle_cnt);
          err_cnt++;
        end
        else
        begin
          check_value("wb_rd_addr_o", wb_rd_addr_o, exp.rd);
          check_value("wb_data_o", wb_data_o, exp.data);
        end
      end
      else if (wb_v_o !== 1'b0)
      begin
        $display("Unexpected writeback in cycle %0d", cycle_cnt);
        err_cnt++;
      end
    end
  end

  always @(posedge clk_i)
  begin
    if (cycle_cnt >= max_cycles)
    begin
      $display("Run did not finish within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    calc_pkg::alu_op_e r_op;
    logic [4:0] r_a1, r_a2, r_rd;
    logic r_kill;
    rst_i = 1'b1;
    dispatch_v_i = 1'b0;
    dispatch_op_i = calc_pkg::e_add;
    dispatch_rs1_addr_i = '0;
    dispatch_rs2_addr_i = '0;
    dispatch_rd_addr_i = '0;
    dispatch_rs1_i = '0;
    dispatch_rs2_i = '0;
    poison_i = 1'b0;
    for (int i = 0; i < 32; i++)
      arch_rf[i] = (i == 0) ? '0 : (i * 32'h0104_1041) ^ 32'hc3a5_0f00;
    stale_rf = arch_rf;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (2) idle_cycle();
    // Every operation on independent registers
    for (int op = 0; op < 8; op++)
      issue_instr(calc_pkg::alu_op_e'(op), 5'd8, 5'd9, 5'(10 + op), 1'b0);
    // Dependents at distance 1 to 4, then two writers of one rd
    for (int d = 1; d <= 4; d++)
    begin
      issue_instr(calc_pkg::e_add, 5'd1, 5'd20, 5'd20, 1'b0);
      repeat (d - 1) idle_cycle();
      issue_instr(calc_pkg::e_xor, 5'd20, 5'd5, 5'd21, 1'b0);
    end
    issue_instr(calc_pkg::e_add, 5'd1, 5'd2, 5'd24, 1'b0);
    issue_instr(calc_pkg::e_sub, 5'd3, 5'd4, 5'd24, 1'b0);
    issue_instr(calc_pkg::e_and, 5'd24, 5'd24, 5'd25, 1'b0);
    // Back-to-back multiplies and their dependents
    issue_instr(calc_pkg::e_mul, 5'd8, 5'd9, 5'd28, 1'b0);
    issue_instr(calc_pkg::e_mul, 5'd10, 5'd11, 5'd29, 1'b0);
    issue_instr(calc_pkg::e_mul, 5'd28, 5'd29, 5'd30, 1'b0);
    issue_instr(calc_pkg::e_add, 5'd30, 5'd28, 5'd31, 1'b0);
    // Poisoned producers are neither written back nor forwarded
    issue_instr(calc_pkg::e_add, 5'd1, 5'd2, 5'd12, 1'b1);
    issue_instr(calc_pkg::e_sub, 5'd12, 5'd1, 5'd13, 1'b0);
    issue_instr(calc_pkg::e_mul, 5'd3, 5'd3, 5'd14, 1'b1);
    issue_instr(calc_pkg::e_add, 5'd14, 5'd1, 5'd15, 1'b0);
    // Writes to x0 stay invisible
    issue_instr(calc_pkg::e_add, 5'd1, 5'd2, 5'd0, 1'b0);
    issue_instr(calc_pkg::e_or, 5'd0, 5'd0, 5'd16, 1'b0);
    repeat (5) idle_cycle();
    for (int n = 0; n < 300; n++)
    begin
      r_op   = calc_pkg::alu_op_e'($random(seed) & 7);
      r_a1   = $random(seed) & 7;
      r_a2   = $random(seed) & 7;
      r_rd   = $random(seed) & 7;
      r_kill = (($random(seed) & 7) == 0);
      issue_instr(r_op, r_a1, r_a2, r_rd, r_kill);
    end
    while (exp_q.size() != 0)
      idle_cycle();
    repeat (3) idle_cycle();
    $display("Errors: %0d, writebacks left: %0d", err_cnt, exp_q.size());
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- source/calc_top.sv
/*
 * Execution calculator top
 *
 * Issue with bypass, integer and multiply pipes and the completion
 * pipeline. One dispatch per cycle, one writeback per cycle.
 */

`include "calc_consts.svh"

module calc_top
  (input  logic                            clk_i
   , input  logic                            rst_i

   , input  logic                            dispatch_v_i
   , input  calc_pkg::alu_op_e               dispatch_op_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rs1_addr_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rs2_addr_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] dispatch_rd_addr_i
   , input  logic [`CALC_DPATH_WIDTH-1:0]    dispatch_rs1_i
   , input  logic [`CALC_DPATH_WIDTH-1:0]    dispatch_rs2_i
   , input  logic                            poison_i

   , output logic                            wb_v_o
   , output logic [`CALC_REG_ADDR_WIDTH-1:0] wb_rd_addr_o
   , output logic [`CALC_DPATH_WIDTH-1:0]    wb_data_o
   );

  logic [`CALC_DPATH_WIDTH-1:0] int_result;
  logic                         mul_v;
  logic [`CALC_DPATH_WIDTH-1:0] mul_result;

  calc_rsv_if rsv_if ();
  calc_fwd_if fwd_if ();

  calc_issue issue
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .dispatch_v_i(dispatch_v_i)
     , .dispatch_op_i(dispatch_op_i)
     , .rs1_addr_i(dispatch_rs1_addr_i)
     , .rs2_addr_i(dispatch_rs2_addr_i)
     , .rd_addr_i(dispatch_rd_addr_i)
     , .rs1_i(dispatch_rs1_i)
     , .rs2_i(dispatch_rs2_i)
     , .poison_i(poison_i)
     , .rsv(rsv_if.issue)
     , .fwd(fwd_if.issue)
     );

  // Integer pipe, result lands in completion stage 0
  calc_pipe_int pipe_int
    (.rsv(rsv_if.pipe)
     , .result_o(int_result)
     );

  // Multiply pipe, result lands in completion stage 1
  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .rsv(rsv_if.pipe)
     , .v_o(mul_v)
     , .result_o(mul_result)
     );

  calc_comp_pipe comp_pipe
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .rsv(rsv_if.comp)
     , .int_result_i(int_result)
     , .mul_v_i(mul_v)
     , .mul_result_i(mul_result)
     , .fwd(fwd_if.comp)
     , .wb_v_o(wb_v_o)
     , .wb_rd_addr_o(wb_rd_addr_o)
     , .wb_data_o(wb_data_o)
     );

endmodule

//--- source/calc_comp_pipe.sv
/*
 * Completion pipeline
 *
 * Fixed-latency shift pipe. Each execution pipe merges its result at
 * its own stage, the last stage drives writeback, and every stage
 * publishes its upcoming value for operand bypassing.
 */

`include "calc_consts.svh"

module calc_comp_pipe
  (input  logic                            clk_i
   , input  logic                            rst_i

   , calc_rsv_if.comp                        rsv
   , input  logic [`CALC_DPATH_WIDTH-1:0]    int_result_i
   , input  logic                            mul_v_i
   , input  logic [`CALC_DPATH_WIDTH-1:0]    mul_result_i

   , calc_fwd_if.comp                        fwd

   , output logic                            wb_v_o
   , output logic [`CALC_REG_ADDR_WIDTH-1:0] wb_rd_addr_o
   , output logic [`CALC_DPATH_WIDTH-1:0]    wb_data_o
   );

  localparam stages_lp = `CALC_COMP_STAGES;

  calc_pkg::comp_stage_s [stages_lp-1:0] stage_n, stage_r;

  always_comb
  begin
    stage_n[0].w_v     = rsv.w_v;
    stage_n[0].rd_addr = rsv.rd_addr;
    stage_n[0].rd_data = int_result_i;
    for (int i = 1; i < stages_lp; i++)
      stage_n[i] = stage_r[i-1];
    // Pipes are zero when idle, so results merge by OR
    if (mul_v_i)
      stage_n[1].rd_data = stage_n[1].rd_data | mul_result_i;
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
    if (rst_i)
    begin
      for (int i = 0; i < stages_lp; i++)
        stage_r[i].w_v <= 1'b0;
    end
  end

  // Entry 0 is the reservation slot with this cycle's ALU result
  always_comb
  begin
    fwd.w_v[0]  = rsv.w_v;
    fwd.addr[0] = rsv.rd_addr;
    fwd.data[0] = stage_n[0].rd_data;
    for (int i = 1; i < stages_lp; i++)
    begin
      fwd.w_v[i]  = stage_r[i-1].w_v;
      fwd.addr[i] = stage_r[i-1].rd_addr;
      fwd.data[i] = stage_n[i].rd_data;
    end
    // Result on the writeback port this cycle
    fwd.w_v[stages_lp]  = stage_r[stages_lp-1].w_v;
    fwd.addr[stages_lp] = stage_r[stages_lp-1].rd_addr;
    fwd.data[stages_lp] = stage_r[stages_lp-1].rd_data;
  end

  assign wb_v_o       = stage_r[stages_lp-1].w_v;
  assign wb_rd_addr_o = stage_r[stages_lp-1].rd_addr;
  assign wb_data_o    = stage_r[stages_lp-1].rd_data;

endmodule

//--- source/calc_pipe_mul.sv
/*
 * Multiply pipe
 *
 * Low-word multiplier with one register stage, so a new multiply
 * can start every cycle.
 */

`include "calc_consts.svh"

module calc_pipe_mul
  (input  logic                          clk_i
   , input  logic                          rst_i
   , calc_rsv_if.pipe                      rsv
   , output logic                          v_o
   , output logic [`CALC_DPATH_WIDTH-1:0]  result_o
   );

  logic                         mul_v;
  logic [`CALC_DPATH_WIDTH-1:0] product;

  assign mul_v   = rsv.v & (rsv.op == calc_pkg::e_mul);
  assign product = rsv.rs1 * rsv.rs2;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      v_o <= 1'b0;
    else
      v_o <= mul_v;
  end

  always_ff @(posedge clk_i)
  begin
    if (mul_v)
      result_o <= product;
  end

endmodule

//--- source/calc_pipe_int.sv
/*
 * Integer ALU pipe
 *
 * Single-cycle add, subtract, logic and shift operations on the
 * reservation operands. Idle slots and MUL produce zero.
 */

`include "calc_consts.svh"

module calc_pipe_int
  (calc_rsv_if.pipe                      rsv
   , output logic [`CALC_DPATH_WIDTH-1:0] result_o
   );

  localparam shamt_width_lp = $clog2(`CALC_DPATH_WIDTH);

  logic [shamt_width_lp-1:0] shamt;

  assign shamt = rsv.rs2[shamt_width_lp-1:0];

  always_comb
  begin
    result_o = '0;
    if (rsv.v)
    begin
      case (rsv.op)
        calc_pkg::e_add: result_o = rsv.rs1 + rsv.rs2;
        calc_pkg::e_sub: result_o = rsv.rs1 - rsv.rs2;
        calc_pkg::e_and: result_o = rsv.rs1 & rsv.rs2;
        calc_pkg::e_or:  result_o = rsv.rs1 | rsv.rs2;
        calc_pkg::e_xor: result_o = rsv.rs1 ^ rsv.rs2;
        calc_pkg::e_sll: result_o = rsv.rs1 << shamt;
        calc_pkg::e_srl: result_o = rsv.rs1 >> shamt;
        // Multiply completes in its own pipe
        default:         result_o = '0;
      endcase
    end
  end

endmodule

//--- source/calc_issue.sv
/*
 * Issue stage
 *
 * Bypasses newer results into the dispatched operands, kills the
 * instruction on poison and loads the reservation register.
 */

`include "calc_consts.svh"

module calc_issue
  (input  logic                            clk_i
   , input  logic                            rst_i

   , input  logic                            dispatch_v_i
   , input  calc_pkg::alu_op_e               dispatch_op_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] rs1_addr_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] rs2_addr_i
   , input  logic [`CALC_REG_ADDR_WIDTH-1:0] rd_addr_i
   , input  logic [`CALC_DPATH_WIDTH-1:0]    rs1_i
   , input  logic [`CALC_DPATH_WIDTH-1:0]    rs2_i
   , input  logic                            poison_i

   , calc_rsv_if.issue                       rsv
   , calc_fwd_if.issue                       fwd
   );

  logic [`CALC_DPATH_WIDTH-1:0]    rs1_byp, rs2_byp;
  logic                            v_n, w_v_n;

  logic                            v_r, w_v_r;
  calc_pkg::alu_op_e               op_r;
  logic [`CALC_DPATH_WIDTH-1:0]    rs1_r, rs2_r;
  logic [`CALC_REG_ADDR_WIDTH-1:0] rd_addr_r;

  // Walk oldest to youngest so the youngest match overrides
  always_comb
  begin
    rs1_byp = rs1_i;
    rs2_byp = rs2_i;
    for (int i = `CALC_COMP_STAGES; i >= 0; i--)
    begin
      if (fwd.w_v[i] && (fwd.addr[i] == rs1_addr_i))
        rs1_byp = fwd.data[i];
      if (fwd.w_v[i] && (fwd.addr[i] == rs2_addr_i))
        rs2_byp = fwd.data[i];
    end
  end

  assign v_n   = dispatch_v_i & ~poison_i;
  // x0 is never written
  assign w_v_n = v_n & (rd_addr_i != '0);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r   <= 1'b0;
      w_v_r <= 1'b0;
    end
    else
    begin
      v_r   <= v_n;
      w_v_r <= w_v_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    op_r      <= dispatch_op_i;
    rs1_r     <= rs1_byp;
    rs2_r     <= rs2_byp;
    rd_addr_r <= rd_addr_i;
  end

  assign rsv.v       = v_r;
  assign rsv.w_v     = w_v_r;
  assign rsv.op      = op_r;
  assign rsv.rs1     = rs1_r;
  assign rsv.rs2     = rs2_r;
  assign rsv.rd_addr = rd_addr_r;

endmodule

//--- source/calc_fwd_if.sv
/*
 * Forwarding bundle
 *
 * One entry per bypass source, ordered youngest first: the
 * reservation register, then completion stages 0, 1 and 2.
 */

`include "calc_consts.svh"

interface calc_fwd_if;

  logic [`CALC_COMP_STAGES:0]                                w_v;
  logic [`CALC_COMP_STAGES:0][`CALC_REG_ADDR_WIDTH-1:0]      addr;
  logic [`CALC_COMP_STAGES:0][`CALC_DPATH_WIDTH-1:0]         data;

  modport comp  (output w_v, addr, data);
  modport issue (input w_v, addr, data);

endinterface

//--- source/calc_rsv_if.sv
/*
 * Reservation register bundle
 *
 * Carries the issued instruction from the reservation register to
 * the execution pipes and the completion pipeline.
 */

`include "calc_consts.svh"

interface calc_rsv_if;

  logic                            v;
  calc_pkg::alu_op_e               op;
  logic [`CALC_DPATH_WIDTH-1:0]    rs1;
  logic [`CALC_DPATH_WIDTH-1:0]    rs2;
  logic [`CALC_REG_ADDR_WIDTH-1:0] rd_addr;
  // Valid with a nonzero destination
  logic                            w_v;

  modport issue (output v, op, rs1, rs2, rd_addr, w_v);
  modport pipe  (input v, op, rs1, rs2);
  modport comp  (input w_v, rd_addr);

endinterface

//--- source/calc_pkg.sv
/*
 * Execution calculator package
 *
 * Operation encoding for the ALU and multiply pipes and the layout
 * of one completion pipeline stage.
 */

`include "calc_consts.svh"

package calc_pkg;

  // Shifts use the low bits of rs2, MUL keeps the low word of the product
  typedef enum logic [2:0]
  {
    e_add = 3'd0
    , e_sub = 3'd1
    , e_and = 3'd2
    , e_or  = 3'd3
    , e_xor = 3'd4
    , e_sll = 3'd5
    , e_srl = 3'd6
    , e_mul = 3'd7
  } alu_op_e;

  typedef struct packed
  {
    logic                            w_v;
    logic [`CALC_REG_ADDR_WIDTH-1:0] rd_addr;
    logic [`CALC_DPATH_WIDTH-1:0]    rd_data;
  } comp_stage_s;

endpackage

//--- include/calc_consts.svh
/*
 * Execution calculator constants
 *
 * Datapath width, register address width and the depth of the
 * fixed-latency completion pipeline.
 */

`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// Integer datapath
`define CALC_DPATH_WIDTH 32
`define CALC_REG_ADDR_WIDTH 5

// Stage 2 is the writeback stage
`define CALC_COMP_STAGES 3

`endif
